//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= mem_stage_tb
FILELIST  ?= mem_stage.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- mem_stage.f
src/mem_pkg.sv
src/except_pkg.sv
src/mem_access.sv
src/data_sram.sv
src/io_timer.sv
src/mem_wb_reg.sv
src/mem_stage.sv
test/mem_stage_chk.sv
test/mem_stage_tb.sv

//--- src/data_sram.sv
`timescale 1ns/100ps
`default_nettype none

module data_sram
    import mem_pkg::*;
(
    input  wire                 clk,
    input  wire                 en,
    input  wire  [3:0]          wen,
    input  wire  [ADDR_W-1:0]   addr,
    input  wire  [DATA_W-1:0]   wdata,
    output logic [DATA_W-1:0]   rdata
);

    logic [DATA_W-1:0]  mem [SRAM_DEPTH];
    logic [SRAM_AW-1:0] idx;

    assign idx = addr[SRAM_AW+1:2]; // upper bits alias

    // per-lane write
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (wen[i])
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    assign rdata = mem[idx]; // async read

endmodule

`default_nettype wire

//--- src/except_pkg.sv
`default_nettype none

package except_pkg;

    localparam int EXCEPT_W = 9;

    // raised in the memory stage
    localparam int EXC_ADES = 0;
    localparam int EXC_ADEL = 1;

    // carried from earlier stages, passed through
    localparam int EXC_ADEF = 2;
    localparam int EXC_RI   = 3;
    localparam int EXC_OV   = 4;
    localparam int EXC_SYS  = 5;
    localparam int EXC_BP   = 6;
    localparam int EXC_INT  = 7;
    localparam int EXC_ERET = 8;

endpackage

`default_nettype wire

//--- src/io_timer.sv
`timescale 1ns/100ps
`default_nettype none

module io_timer
    import mem_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 io_sel,
    input  wire  [3:0]          wen,
    input  wire  [DATA_W-1:0]   wdata,
    input  wire  [DATA_W-1:0]   sram_rdata,
    output logic [DATA_W-1:0]   bus_rdata
);

    logic [DATA_W-1:0] count;

    // free-running, SW to the timer word reloads it
    always_ff @(posedge clk) begin
        if (rst)
            count <= '0;
        else if (io_sel && wen == 4'b1111)
            count <= wdata;
        else
            count <= count + 1'b1;
    end

    assign bus_rdata = io_sel ? count : sram_rdata;

endmodule

`default_nettype wire

//--- src/mem_access.sv
`timescale 1ns/100ps
`default_nettype none

module mem_access
    import mem_pkg::*;
    import except_pkg::*;
(
    input  wire  [OP_W-1:0]     op,
    input  wire                 mem_en,
    input  wire  [ADDR_W-1:0]   mem_addr,
    input  wire  [DATA_W-1:0]   mem_wdata,
    input  wire  [EXCEPT_W-1:0] except_in,
    input  wire  [DATA_W-1:0]   bus_rdata,
    output logic [DATA_W-1:0]   mem_rdata,
    output logic [EXCEPT_W-1:0] except_out,
    output logic                sram_en,
    output logic [3:0]          sram_wen,
    output logic [ADDR_W-1:0]   sram_addr,
    output logic [DATA_W-1:0]   sram_wdata,
    output logic                io_sel
);

    logic        adel;
    logic        ades;
    logic        fault;
    logic [3:0]  lanes;     // byte lanes before enable gating
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    assign byte_lane = bus_rdata[{mem_addr[1:0], 3'b000} +: 8];
    assign half_lane = mem_addr[1] ? bus_rdata[31:16] : bus_rdata[15:0];

    always_comb begin
        adel       = 1'b0;
        ades       = 1'b0;
        lanes      = 4'b0000;
        mem_rdata  = '0;
        sram_wdata = '0;
        case (op)
            OP_LW: begin
                if (mem_addr[1:0] != 2'b00)
                    adel = 1'b1;
                else
                    mem_rdata = bus_rdata;
            end
            OP_LH: begin
                if (mem_addr[0])
                    adel = 1'b1;
                else
                    mem_rdata = {{16{half_lane[15]}}, half_lane};
            end
            OP_LHU: begin
                if (mem_addr[0])
                    adel = 1'b1;
                else
                    mem_rdata = {16'h0000, half_lane};
            end
            OP_LB:  mem_rdata = {{24{byte_lane[7]}}, byte_lane};
            OP_LBU: mem_rdata = {24'h00_0000, byte_lane};
            OP_SW: begin
                if (mem_addr[1:0] != 2'b00) begin
                    ades = 1'b1;
                end else begin
                    sram_wdata = mem_wdata;
                    lanes      = 4'b1111;
                end
            end
            OP_SH: begin
                if (mem_addr[0]) begin
                    ades = 1'b1;
                end else begin
                    sram_wdata = {2{mem_wdata[15:0]}};
                    lanes      = mem_addr[1] ? 4'b1100 : 4'b0011;
                end
            end
            OP_SB: begin
                sram_wdata = {4{mem_wdata[7:0]}};
                lanes      = 4'b0001 << mem_addr[1:0];
            end
            default: ;
        endcase
    end

    // bits 8:2 pass through, the two address errors land in 1:0
    always_comb begin
        except_out           = except_in;
        except_out[EXC_ADEL] = adel;
        except_out[EXC_ADES] = ades;
    end

    assign fault  = |except_out;
    assign io_sel = (mem_addr == TIMER_ADDR);

    // the timer word never reaches the memory
    assign sram_en   = mem_en && !fault && !io_sel;
    assign sram_addr = mem_addr;

    // lanes not masked by io_sel, the timer takes them on io_sel
    assign sram_wen = (mem_en && !fault) ? lanes : 4'b0000;

endmodule

`default_nettype wire

//--- src/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int OP_W   = 6;

    // MIPS primary opcodes for loads and stores
    localparam logic [OP_W-1:0] OP_LB  = 6'b100000;
    localparam logic [OP_W-1:0] OP_LH  = 6'b100001;
    localparam logic [OP_W-1:0] OP_LW  = 6'b100011;
    localparam logic [OP_W-1:0] OP_LBU = 6'b100100;
    localparam logic [OP_W-1:0] OP_LHU = 6'b100101;
    localparam logic [OP_W-1:0] OP_SB  = 6'b101000;
    localparam logic [OP_W-1:0] OP_SH  = 6'b101001;
    localparam logic [OP_W-1:0] OP_SW  = 6'b101011;

    // local data memory, 1 KiB
    localparam int SRAM_DEPTH = 256;
    localparam int SRAM_AW    = 8;

    localparam logic [ADDR_W-1:0] TIMER_ADDR = 32'hbfaf_fff0; // cycle counter word

endpackage

`default_nettype wire

//--- src/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage
    import mem_pkg::*;
    import except_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire  [OP_W-1:0]     op,
    input  wire                 mem_en,
    input  wire  [ADDR_W-1:0]   mem_addr,
    input  wire  [DATA_W-1:0]   mem_wdata,
    input  wire  [EXCEPT_W-1:0] except_in,
    input  wire                 stall,
    output logic [DATA_W-1:0]   wb_rdata,
    output logic [EXCEPT_W-1:0] wb_except,
    output logic                wb_valid
);

    logic                sram_en;
    logic [3:0]          sram_wen;
    logic [ADDR_W-1:0]   sram_addr;
    logic [DATA_W-1:0]   sram_wdata;
    logic [DATA_W-1:0]   sram_rdata;
    logic [DATA_W-1:0]   bus_rdata;   // memory or timer
    logic                io_sel;
    logic [DATA_W-1:0]   mem_rdata;
    logic [EXCEPT_W-1:0] except_out;

    mem_access u_mem_access (
        .op         (op),
        .mem_en     (mem_en),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .except_in  (except_in),
        .bus_rdata  (bus_rdata),
        .mem_rdata  (mem_rdata),
        .except_out (except_out),
        .sram_en    (sram_en),
        .sram_wen   (sram_wen),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .io_sel     (io_sel)
    );

    data_sram u_data_sram (
        .clk   (clk),
        .en    (sram_en),
        .wen   (sram_wen),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    io_timer u_io_timer (
        .clk        (clk),
        .rst        (rst),
        .io_sel     (io_sel),
        .wen        (sram_wen),
        .wdata      (sram_wdata),
        .sram_rdata (sram_rdata),
        .bus_rdata  (bus_rdata)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .mem_en    (mem_en),
        .mem_rdata (mem_rdata),
        .except_in (except_out),
        .wb_valid  (wb_valid),
        .wb_rdata  (wb_rdata),
        .wb_except (wb_except)
    );

endmodule

`default_nettype wire

//--- src/mem_wb_reg.sv
`timescale 1ns/100ps
`default_nettype none

module mem_wb_reg
    import mem_pkg::*;
    import except_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 stall,
    input  wire                 mem_en,
    input  wire  [DATA_W-1:0]   mem_rdata,
    input  wire  [EXCEPT_W-1:0] except_in,
    output logic                wb_valid,
    output logic [DATA_W-1:0]   wb_rdata,
    output logic [EXCEPT_W-1:0] wb_except
);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid  <= 1'b0;
            wb_rdata  <= '0;
            wb_except <= '0;
        end else if (!stall) begin
            wb_valid  <= mem_en;
            wb_except <= except_in;
            // no data from a faulting access
            wb_rdata  <= (|except_in) ? '0 : mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- test/mem_stage_chk.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage_chk
    import mem_pkg::*;
    import except_pkg::*;
(
    input wire                clk,
    input wire                rst,
    input wire [ADDR_W-1:0]   mem_addr,
    input wire [EXCEPT_W-1:0] except_in,
    input wire                sram_en,
    input wire [3:0]          sram_wen
);

    int fail_count = 0; // failed assertions

    // the timer takes store lanes while the memory stays disabled
    a_wen_gated: assert property (@(posedge clk) disable iff (rst)
        (sram_wen != 4'b0000) |-> (sram_en || mem_addr == TIMER_ADDR))
        else begin
            fail_count++;
            $error("byte enable set with memory and timer idle");
        end

    a_io_excl: assert property (@(posedge clk) disable iff (rst)
        (mem_addr == TIMER_ADDR) |-> !sram_en)
        else begin
            fail_count++;
            $error("memory enabled for the timer word");
        end

    // causes from earlier stages must kill the write
    a_exc_gated: assert property (@(posedge clk) disable iff (rst)
        (except_in[EXCEPT_W-1:EXC_ADEF] != '0) |-> !sram_en)
        else begin
            fail_count++;
            $error("memory enabled with an earlier exception pending");
        end

endmodule

bind mem_stage mem_stage_chk chk (.clk(clk), .rst(rst), .mem_addr(mem_addr),
                                  .except_in(except_in), .sram_en(sram_en),
                                  .sram_wen(sram_wen));

`default_nettype wire

//--- test/mem_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage_tb
    import mem_pkg::*;
    import except_pkg::*;
();

    localparam logic [31:0] SEED = 32'hc446_9891;
    localparam int N_REQ = SRAM_DEPTH + 50*2 + 20*13 + 40*2 + 40*2 + 5*11 + 10*5 + 2;

    logic clk = 1'b0;
    logic rst, mem_en, stall, wb_valid;
    logic [OP_W-1:0] op;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata, wb_rdata, shadow_timer, exp_rdata, prev_rdata;
    logic [EXCEPT_W-1:0] except_in, wb_except, exp_except, prev_except;
    logic [DATA_W-1:0] shadow_mem [SRAM_DEPTH];
    logic exp_valid, prev_valid;
    logic cur_check = 1'b0;
    logic prev_check = 1'b0;
    int errors = 0;
    int checks = 0;

    mem_stage dut (.clk(clk), .rst(rst), .op(op), .mem_en(mem_en), .mem_addr(mem_addr),
                   .mem_wdata(mem_wdata), .except_in(except_in), .stall(stall),
                   .wb_rdata(wb_rdata), .wb_except(wb_except), .wb_valid(wb_valid));

    always #5 clk = ~clk;

    // expected {exception vector, load data} for one request
    function automatic logic [EXCEPT_W+DATA_W-1:0] expect_result(input logic [OP_W-1:0] o,
            input logic [ADDR_W-1:0] a, input logic [EXCEPT_W-1:0] e, input logic [DATA_W-1:0] w);
        logic [EXCEPT_W-1:0] exc;
        logic [DATA_W-1:0] data;
        logic [7:0] b;
        logic [15:0] h;
        case (a[1:0])
            2'd0: b = w[7:0];
            2'd1: b = w[15:8];
            2'd2: b = w[23:16];
            default: b = w[31:24];
        endcase
        h = 16'(w >> (16 * int'(a[1])));
        exc = e;
        exc[EXC_ADEL] = (o == OP_LW && a[1:0] != 2'b00) || ((o == OP_LH || o == OP_LHU) && a[0]);
        exc[EXC_ADES] = (o == OP_SW && a[1:0] != 2'b00) || (o == OP_SH && a[0]);
        case (o)
            OP_LW:   data = w;
            OP_LH:   data = {{16{h[15]}}, h};
            OP_LHU:  data = {16'h0000, h};
            OP_LB:   data = {{24{b[7]}}, b};
            OP_LBU:  data = {24'h00_0000, b};
            default: data = '0;
        endcase
        if (|exc)
            data = '0; // writeback never sees faulting data
        return {exc, data};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v, input logic [31:0] act);
        checks++;
        if (act !== exp_v) begin
            errors++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp_v, act);
        end
    endtask

    // shadow state update for the request presented this cycle
    task automatic model(input logic [OP_W-1:0] o, input logic en, input logic [ADDR_W-1:0] a,
            input logic [DATA_W-1:0] d, input logic [EXCEPT_W-1:0] e, input logic s);
        logic [EXCEPT_W+DATA_W-1:0] r;
        logic [SRAM_AW-1:0] idx;
        logic wr;
        idx = a[SRAM_AW+1:2];
        r = expect_result(o, a, e, (a == TIMER_ADDR) ? shadow_timer : shadow_mem[idx]);
        wr = en && (r[DATA_W +: EXCEPT_W] == '0);
        if (!s) begin
            exp_valid = en;
            exp_except = r[DATA_W +: EXCEPT_W];
            exp_rdata = r[DATA_W-1:0];
        end
        if (wr && a != TIMER_ADDR) begin
            case (o)
                OP_SW: shadow_mem[idx] = d;
                OP_SH: shadow_mem[idx][16*int'(a[1]) +: 16] = d[15:0];
                OP_SB: shadow_mem[idx][8*int'(a[1:0]) +: 8] = d[7:0];
                default: ;
            endcase
        end
        shadow_timer = (wr && a == TIMER_ADDR && o == OP_SW) ? d : shadow_timer + 1;
        cur_check = 1'b1;
    endtask

    task automatic issue(input logic [OP_W-1:0] o, input logic en, input logic [ADDR_W-1:0] a,
            input logic [DATA_W-1:0] d, input logic [EXCEPT_W-1:0] e, input logic s);
        @(posedge clk);
        op <= o;
        mem_en <= en;
        mem_addr <= a;
        mem_wdata <= d;
        except_in <= e;
        stall <= s;
        model(o, en, a, d, e, s);
    endtask

    function automatic logic [ADDR_W-1:0] rand_addr();
        logic [ADDR_W-1:0] a;
        a = $urandom;
        a[31] = 1'b0; // keeps clear of the timer word
        a[1:0] = 2'b00;
        return a;
    endfunction

    // outputs settle long before the falling edge
    always @(negedge clk) begin
        if (prev_check) begin
            check_val("wb_valid", 32'(prev_valid), 32'(wb_valid));
            check_val("wb_except", 32'(prev_except), 32'(wb_except));
            check_val("wb_rdata", prev_rdata, wb_rdata);
        end
        prev_check = cur_check;
        prev_valid = exp_valid;
        prev_except = exp_except;
        prev_rdata = exp_rdata;
    end

    initial begin
        #(N_REQ * 10 + 500);
        $display("timeout, the stimulus did not finish in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [ADDR_W-1:0] a;
        logic [OP_W-1:0] o;
        logic [1:0] off;
        int k;
        void'($urandom(SEED));
        rst = 1'b1;
        op = '0;
        mem_en = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        except_in = '0;
        stall = 1'b0;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_val("wb_valid", 32'd0, 32'(wb_valid));
        check_val("wb_except", 32'd0, 32'(wb_except));
        check_val("wb_rdata", 32'd0, wb_rdata);
        @(posedge clk);
        rst <= 1'b0;
        shadow_timer = '0;
        model('0, 1'b0, '0, '0, '0, 1'b0);
        for (int i = 0; i < SRAM_DEPTH; i++)
            issue(OP_SW, 1'b1, 32'(i) << 2, $urandom, '0, 1'b0);
        for (int i = 0; i < 50; i++) begin
            a = rand_addr();
            issue(OP_SW, 1'b1, a, $urandom, '0, 1'b0);
            issue(OP_LW, 1'b1, a, '0, '0, 1'b0);
        end
        for (int i = 0; i < 20; i++) begin // byte and half lanes
            a = rand_addr();
            o = ($urandom_range(0, 1) == 0) ? OP_SB : OP_SH;
            off = 2'($urandom_range(0, 3));
            if (o == OP_SH)
                off[0] = 1'b0;
            issue(o, 1'b1, a | {30'd0, off}, $urandom, '0, 1'b0);
            for (int j = 0; j < 4; j++) begin
                issue(OP_LB, 1'b1, a | 32'(j), '0, '0, 1'b0);
                issue(OP_LBU, 1'b1, a | 32'(j), '0, '0, 1'b0);
                issue((j < 2) ? OP_LH : OP_LHU, 1'b1, a | 32'(2 * (j % 2)), '0, '0, 1'b0);
            end
        end
        for (int i = 0; i < 40; i++) begin // misaligned
            a = rand_addr();
            k = $urandom_range(0, 3);
            o = (k == 0) ? OP_LW : (k == 1) ? OP_LH : (k == 2) ? OP_SW : OP_SH;
            off = 2'($urandom_range(1, 3));
            if (k[0])
                off[0] = 1'b1;
            issue(o, 1'b1, a | {30'd0, off}, $urandom, '0, 1'b0);
            issue(OP_LW, 1'b1, a, '0, '0, 1'b0);
        end
        for (int i = 0; i < 40; i++) begin // earlier-stage exceptions
            a = rand_addr();
            o = ($urandom_range(0, 1) == 0) ? OP_SW : OP_LW;
            issue(o, 1'b1, a, $urandom, 9'($urandom_range(1, 127)) << 2, 1'b0);
            issue(OP_LW, 1'b1, a, '0, '0, 1'b0);
        end
        for (int i = 0; i < 5; i++) begin
            issue(OP_SW, 1'b1, TIMER_ADDR, $urandom, '0, 1'b0);
            repeat ($urandom_range(1, 8)) issue('0, 1'b0, '0, '0, '0, 1'b0);
            issue(OP_LW, 1'b1, TIMER_ADDR, '0, '0, 1'b0);
            issue(OP_LW, 1'b1, TIMER_ADDR & 32'h0000_03fc, '0, '0, 1'b0); // aliased word
        end
        for (int i = 0; i < 10; i++) begin
            issue(OP_LW, 1'b1, rand_addr(), '0, '0, 1'b0);
            repeat ($urandom_range(1, 3)) issue(OP_LW, 1'b0, rand_addr(), '0, '0, 1'b1);
            issue('0, 1'b0, '0, '0, '0, 1'b0);
        end
        issue('0, 1'b0, '0, '0, '0, 1'b0);
        repeat (2) @(negedge clk);
        @(posedge clk); // last comparison is done by now
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
                 dut.chk.fail_count);
        if (errors == 0 && dut.chk.fail_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
